// File: filelist.f
verilog/hazardPkg.sv
verilog/pipeReg.sv
verilog/stallDetect.sv
verilog/forwardSelect.sv
verilog/hazardArbiter.sv
verilog/hazardCore.sv
verification/tbHazardCore.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the hazard-control testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbHazardCore \
    -f filelist.f \
    -o simHazardCore

simOutput=$(./obj_dir/simHazardCore)
echo "$simOutput"

if grep -qx "TESTS PASSED" <<< "$simOutput"; then
    exit 0
else
    exit 1
fi

// File: verification/tbHazardCore.sv
`timescale 1ns/100ps

module tbHazardCore
    import hazardPkg::*;
();

    localparam int clkPeriod      = 8;
    localparam int resetCycles    = 8;
    localparam int directedCycles = 100;
    localparam int randomCycles   = 2000;
    localparam int marginCycles   = 200;

    typedef struct packed {
        logic   stallF;
        logic   stallD;
        logic   stallE;
        logic   stallM;
        logic   flushD;
        logic   flushE;
        logic   flushM;
        fwdSelT fAD;
        fwdSelT fBD;
        fwdSelT fAE;
        fwdSelT fBE;
    } expectT;

    logic    clk;
    logic    rstN;
    regAddrT decRa1, decRa2, decDst;
    logic    decWr, decMemRead, decMultiAlu, decBranchUse, decRedirect;
    logic    iWait, dWait, eWait;
    logic    stallF, stallD, stallE, stallM, flushD, flushE, flushM;
    fwdSelT  forwardAD, forwardBD, forwardAE, forwardBE;

    eStageT  eModel;    // Shadow copies of the three stage records.
    mStageT  mModel;
    wStageT  wModel;
    int      errorCount;
    int      checkCount;
    int      seed;

    hazardCore hazardCore_inst (
        .clk          (clk),
        .rstN         (rstN),
        .decRa1       (decRa1),
        .decRa2       (decRa2),
        .decDst       (decDst),
        .decWr        (decWr),
        .decMemRead   (decMemRead),
        .decMultiAlu  (decMultiAlu),
        .decBranchUse (decBranchUse),
        .decRedirect  (decRedirect),
        .iWait        (iWait),
        .dWait        (dWait),
        .eWait        (eWait),
        .stallF       (stallF),
        .stallD       (stallD),
        .stallE       (stallE),
        .stallM       (stallM),
        .flushD       (flushD),
        .flushE       (flushE),
        .flushM       (flushM),
        .forwardAD    (forwardAD),
        .forwardBD    (forwardBD),
        .forwardAE    (forwardAE),
        .forwardBE    (forwardBE)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic fwdSelT expectSource(input regAddrT src, input mStageT m,
                                            input wStageT w);
        if (src == regZero) return fwdNone;
        if (m.wr && (src == m.dst)) return fwdFromM;    // Younger result first.
        if (w.wr && (src == w.dst)) return fwdFromW;
        return fwdNone;
    endfunction

    // Expected commands and selections for the current decode inputs and records.
    function automatic expectT predict(input eStageT e, input mStageT m, input wStageT w);
        expectT x;
        logic   srcInE;
        logic   early;
        logic   memWrDep;
        logic   luReq;
        logic   brReq;
        logic   muReq;
        srcInE   = (decRa1 == e.dst) || (decRa2 == e.dst);
        early    = (e.wr && srcInE) || (m.memRead && ((decRa1 == m.dst) || (decRa2 == m.dst)));
        memWrDep = m.wr && (((decRa1 != regZero) && (decRa1 == m.dst))
                         || ((decRa2 != regZero) && (decRa2 == m.dst)));
        luReq    = e.memRead && (e.dst != regZero) && srcInE;
        brReq    = decBranchUse && early;
        muReq    = decMultiAlu && (early || memWrDep);
        x = '0;
        if (eWait) begin
            x.stallF = 1'b1;
            x.stallD = 1'b1;
            x.stallE = 1'b1;
            x.stallM = dWait;
            x.flushM = !dWait;
        end else if (dWait) begin
            x.stallF = 1'b1;
            x.stallD = 1'b1;
            x.stallE = 1'b1;
            x.stallM = 1'b1;
        end else if (iWait) begin
            x.stallF = 1'b1;
            x.stallD = decRedirect || brReq || muReq;    // No load-use hold here.
            x.flushE = x.stallD;
            x.flushD = !x.stallD;
        end else begin
            x.stallF = luReq || brReq || muReq;
            x.stallD = x.stallF;
            x.flushE = x.stallF;
            x.flushD = decRedirect && !brReq;
        end
        x.fAD = expectSource(decRa1, m, w);
        x.fBD = expectSource(decRa2, m, w);
        x.fAE = expectSource(e.ra1, m, w);
        x.fBE = expectSource(e.ra2, m, w);
        if (eWait && !m.multiAlu) begin
            x.fAE = fwdNone;
            x.fBE = fwdNone;
        end
        return x;
    endfunction

    task automatic compareLogic(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compareFwd(input string name, input fwdSelT got, input fwdSelT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic issue(input regAddrT ra1, input regAddrT ra2, input regAddrT dst,
                         input logic wr, input logic memRead, input logic multiAlu,
                         input logic branchUse, input logic redirect);
        @(posedge clk);
        decRa1       <= ra1;
        decRa2       <= ra2;
        decDst       <= dst;
        decWr        <= wr;
        decMemRead   <= memRead;
        decMultiAlu  <= multiAlu;
        decBranchUse <= branchUse;
        decRedirect  <= redirect;
    endtask

    task automatic setWaits(input logic iw, input logic dw, input logic ew);
        iWait <= iw;
        dWait <= dw;
        eWait <= ew;
    endtask

    // The shadow records follow the model's own commands, not the DUT's.
    always @(posedge clk or negedge rstN) begin : shadowUpdate
        expectT cmd;
        if (!rstN) begin
            eModel <= '0;
            mModel <= '0;
            wModel <= '0;
        end else begin
            cmd = predict(eModel, mModel, wModel);
            wModel <= cmd.stallM ? wStageT'('0) : wStageT'{dst: mModel.dst, wr: mModel.wr};
            if (cmd.flushM) begin
                mModel <= '0;
            end else if (!cmd.stallM) begin
                mModel <= '{dst: eModel.dst, wr: eModel.wr, memRead: eModel.memRead,
                            multiAlu: eModel.multiAlu};
            end
            if (cmd.flushE) begin
                eModel <= '0;
            end else if (!cmd.stallE) begin
                eModel <= '{ra1: decRa1, ra2: decRa2, dst: decDst, wr: decWr,
                            memRead: decMemRead, multiAlu: decMultiAlu};
            end
        end
    end

    always @(negedge clk) begin : compareOutputs
        expectT exp;
        if (rstN) begin
            exp = predict(eModel, mModel, wModel);
            compareLogic("stallF", stallF, exp.stallF);
            compareLogic("stallD", stallD, exp.stallD);
            compareLogic("stallE", stallE, exp.stallE);
            compareLogic("stallM", stallM, exp.stallM);
            compareLogic("flushD", flushD, exp.flushD);
            compareLogic("flushE", flushE, exp.flushE);
            compareLogic("flushM", flushM, exp.flushM);
            compareFwd("forwardAD", forwardAD, exp.fAD);
            compareFwd("forwardBD", forwardBD, exp.fBD);
            compareFwd("forwardAE", forwardAE, exp.fAE);
            compareFwd("forwardBE", forwardBE, exp.fBE);
        end
    end

    initial begin : watchdog
        #((resetCycles + directedCycles + randomCycles + marginCycles) * clkPeriod);
        $display("Timeout: the stimulus did not complete in the expected run time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        int r;
        clk          = 1'b0;
        rstN         = 1'b0;
        decRa1       = '0;
        decRa2       = '0;
        decDst       = '0;
        decWr        = 1'b0;
        decMemRead   = 1'b0;
        decMultiAlu  = 1'b0;
        decBranchUse = 1'b0;
        decRedirect  = 1'b0;
        iWait        = 1'b0;
        dWait        = 1'b0;
        eWait        = 1'b0;
        errorCount   = 0;
        checkCount   = 0;
        seed         = 25945;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        // Idle after reset.
        repeat (3) issue(0, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        compareLogic("stallF", stallF, 1'b0);
        compareFwd("forwardAD", forwardAD, fwdNone);

        // Forwarding distances, priority and register zero.
        issue(0, 0, 5, 1, 0, 0, 0, 0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(5, 5, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        compareFwd("forwardAD", forwardAD, fwdFromM);
        compareFwd("forwardBD", forwardBD, fwdFromM);
        issue(5, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        compareFwd("forwardAD", forwardAD, fwdFromW);
        issue(0, 0, 6, 1, 0, 0, 0, 0);
        issue(0, 0, 6, 1, 0, 0, 0, 0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(6, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        compareFwd("forwardAD", forwardAD, fwdFromM);
        issue(0, 0, 0, 1, 0, 0, 0, 0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        compareFwd("forwardAD", forwardAD, fwdNone);

        // Load followed by a reader.
        issue(0, 0, 7, 1, 1, 0, 0, 0);
        issue(7, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        compareLogic("stallF", stallF, 1'b1);
        compareLogic("stallD", stallD, 1'b1);
        compareLogic("flushE", flushE, 1'b1);
        issue(7, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        compareLogic("stallD", stallD, 1'b0);
        compareFwd("forwardAD", forwardAD, fwdFromM);

        // Branch operands from execute and from a load in memory, then a clean taken branch.
        repeat (2) issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(0, 0, 3, 1, 0, 0, 0, 0);
        issue(3, 0, 0, 0, 0, 0, 1, 0);
        @(negedge clk);
        compareLogic("stallD", stallD, 1'b1);
        compareLogic("flushE", flushE, 1'b1);
        issue(0, 0, 4, 1, 1, 0, 0, 0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(4, 0, 0, 0, 0, 0, 1, 0);
        @(negedge clk);
        compareLogic("stallD", stallD, 1'b1);
        repeat (3) issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(9, 10, 0, 0, 0, 0, 1, 1);
        @(negedge clk);
        compareLogic("flushD", flushD, 1'b1);
        compareLogic("stallD", stallD, 1'b0);
        compareLogic("flushE", flushE, 1'b0);

        // Wait levels and their priority.
        repeat (2) issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(0, 0, 2, 1, 0, 0, 0, 0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(2, 0, 0, 0, 0, 0, 0, 0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        setWaits(1'b0, 1'b0, 1'b1);
        @(negedge clk);
        compareLogic("stallE", stallE, 1'b1);
        compareLogic("flushM", flushM, 1'b1);
        compareFwd("forwardAE", forwardAE, fwdNone);    // Writeback match is gated.
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        setWaits(1'b0, 1'b1, 1'b1);
        @(negedge clk);
        compareLogic("stallM", stallM, 1'b1);
        compareLogic("flushM", flushM, 1'b0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        setWaits(1'b0, 1'b1, 1'b0);
        @(negedge clk);
        compareLogic("stallM", stallM, 1'b1);
        compareLogic("stallF", stallF, 1'b1);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        setWaits(1'b1, 1'b0, 1'b0);
        @(negedge clk);
        compareLogic("flushD", flushD, 1'b1);
        compareLogic("stallD", stallD, 1'b0);
        issue(0, 0, 0, 0, 0, 0, 0, 1);
        @(negedge clk);
        compareLogic("stallD", stallD, 1'b1);
        compareLogic("flushE", flushE, 1'b1);
        compareLogic("flushD", flushD, 1'b0);
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        setWaits(1'b0, 1'b0, 1'b0);

        // Random stream over a small register range so that matches are frequent.
        for (int n = 0; n < randomCycles; n++) begin
            r = $random(seed);
            issue({2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}, r[9],
                  r[11:10] == 2'b00, r[13:12] == 2'b00, r[15:14] == 2'b00,
                  r[18:16] == 3'b000);
            setWaits(r[21:19] == 3'b000, r[24:22] == 3'b000, r[27:25] == 3'b000);
        end
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        setWaits(1'b0, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk);

        $display("Checks run: %0d, errors found: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/forwardSelect.sv
`timescale 1ns/100ps

module forwardSelect
    import hazardPkg::*;
(
    input  regAddrT ra1,
    input  regAddrT ra2,
    input  regAddrT ra1E,
    input  regAddrT ra2E,
    input  regAddrT mDst,
    input  regAddrT wDst,
    input  logic    mWr,
    input  logic    wWr,
    output fwdSelT  fwdAD,
    output fwdSelT  fwdBD,
    output fwdSelT  fwdAE,
    output fwdSelT  fwdBE
);

    // Memory holds the younger result, so it wins over writeback.
    function automatic fwdSelT pickSource(
        input regAddrT src,
        input regAddrT mDstIn,
        input logic    mWrIn,
        input regAddrT wDstIn,
        input logic    wWrIn
    );
        fwdSelT sel;
        sel = fwdNone;
        if (src != regZero) begin
            if (mWrIn && (src == mDstIn)) begin
                sel = fwdFromM;
            end else if (wWrIn && (src == wDstIn)) begin
                sel = fwdFromW;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdAD = pickSource(ra1, mDst, mWr, wDst, wWr);
        fwdBD = pickSource(ra2, mDst, mWr, wDst, wWr);
        fwdAE = pickSource(ra1E, mDst, mWr, wDst, wWr);    // Raw, gated later on eWait.
        fwdBE = pickSource(ra2E, mDst, mWr, wDst, wWr);
    end

endmodule

// File: verilog/hazardArbiter.sv
`timescale 1ns/100ps

module hazardArbiter
    import hazardPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   iWait,
    input  logic   dWait,
    input  logic   eWait,
    input  logic   redirect,
    input  logic   mMultiAlu,
    input  logic   loadUseReq,
    input  logic   branchReq,
    input  logic   multiReq,
    input  fwdSelT fwdAEIn,
    input  fwdSelT fwdBEIn,
    output logic   stallF,
    output logic   stallD,
    output logic   stallE,
    output logic   stallM,
    output logic   flushD,
    output logic   flushE,
    output logic   flushM,
    output fwdSelT forwardAE,
    output fwdSelT forwardBE
);

    logic anyReq;
    logic holdDecode;
    logic gateFwdE;

    assign anyReq     = loadUseReq || branchReq || multiReq;
    assign holdDecode = redirect || branchReq || multiReq;    // Load-use ignored under iWait.

    always_comb begin
        stallF = 1'b0;
        stallD = 1'b0;
        stallE = 1'b0;
        stallM = 1'b0;
        flushD = 1'b0;
        flushE = 1'b0;
        flushM = 1'b0;

        if (eWait) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallE = 1'b1;
            if (dWait) begin
                stallM = 1'b1;    // Memory stage is busy too, keep it.
            end else begin
                flushM = 1'b1;
            end
        end else if (dWait) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallE = 1'b1;
            stallM = 1'b1;
        end else if (iWait) begin
            stallF = 1'b1;
            if (holdDecode) begin
                stallD = 1'b1;    // Keep the decode instruction, bubble execute.
                flushE = 1'b1;
            end else begin
                flushD = 1'b1;
            end
        end else begin
            stallF = anyReq;
            stallD = anyReq;
            flushE = anyReq;
            flushD = redirect && !branchReq;
        end
    end

    // Execute operands are frozen during eWait; only a multi-cycle result may feed back.
    assign gateFwdE  = eWait && !mMultiAlu;
    assign forwardAE = gateFwdE ? fwdNone : fwdAEIn;
    assign forwardBE = gateFwdE ? fwdNone : fwdBEIn;

    stallFlushExclE: assert property (
        @(posedge clk) disable iff (!rstN)
        !(flushE && stallE)
    ) else $error("hazardArbiter: execute stalled and flushed together");

    stallOrderME: assert property (
        @(posedge clk) disable iff (!rstN)
        stallM |-> stallE
    ) else $error("hazardArbiter: memory stalled while execute advances");

endmodule

// File: verilog/hazardCore.sv
`timescale 1ns/100ps

module hazardCore
    import hazardPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT decRa1,
    input  regAddrT decRa2,
    input  regAddrT decDst,
    input  logic    decWr,
    input  logic    decMemRead,
    input  logic    decMultiAlu,
    input  logic    decBranchUse,
    input  logic    decRedirect,
    input  logic    iWait,
    input  logic    dWait,
    input  logic    eWait,
    output logic    stallF,
    output logic    stallD,
    output logic    stallE,
    output logic    stallM,
    output logic    flushD,
    output logic    flushE,
    output logic    flushM,
    output fwdSelT  forwardAD,
    output fwdSelT  forwardBD,
    output fwdSelT  forwardAE,
    output fwdSelT  forwardBE
);

    eStageT eIn;
    eStageT eStage;
    mStageT mIn;
    mStageT mStage;
    wStageT wIn;
    wStageT wStage;

    logic   loadUseReq;
    logic   branchReq;
    logic   multiReq;
    fwdSelT fwdAE;
    fwdSelT fwdBE;

    assign eIn = '{ra1: decRa1, ra2: decRa2, dst: decDst, wr: decWr,
                   memRead: decMemRead, multiAlu: decMultiAlu};
    assign mIn = '{dst: eStage.dst, wr: eStage.wr, memRead: eStage.memRead,
                   multiAlu: eStage.multiAlu};
    assign wIn = '{dst: mStage.dst, wr: mStage.wr};

    pipeReg #(.payloadT(eStageT)) eReg_inst (
        .clk    (clk),
        .rstN   (rstN),
        .hold   (stallE),
        .bubble (flushE),
        .d      (eIn),
        .q      (eStage)
    );

    pipeReg #(.payloadT(mStageT)) mReg_inst (
        .clk    (clk),
        .rstN   (rstN),
        .hold   (stallM),
        .bubble (flushM),
        .d      (mIn),
        .q      (mStage)
    );

    // Writeback never holds; a memory stall drains it with a bubble.
    pipeReg #(.payloadT(wStageT)) wReg_inst (
        .clk    (clk),
        .rstN   (rstN),
        .hold   (1'b0),
        .bubble (stallM),
        .d      (wIn),
        .q      (wStage)
    );

    stallDetect stallDetect_inst (
        .clk        (clk),
        .rstN       (rstN),
        .ra1        (decRa1),
        .ra2        (decRa2),
        .branchUse  (decBranchUse),
        .multiAlu   (decMultiAlu),
        .eDst       (eStage.dst),
        .eWr        (eStage.wr),
        .eMemRead   (eStage.memRead),
        .mDst       (mStage.dst),
        .mWr        (mStage.wr),
        .mMemRead   (mStage.memRead),
        .loadUseReq (loadUseReq),
        .branchReq  (branchReq),
        .multiReq   (multiReq)
    );

    forwardSelect forwardSelect_inst (
        .ra1   (decRa1),
        .ra2   (decRa2),
        .ra1E  (eStage.ra1),
        .ra2E  (eStage.ra2),
        .mDst  (mStage.dst),
        .wDst  (wStage.dst),
        .mWr   (mStage.wr),
        .wWr   (wStage.wr),
        .fwdAD (forwardAD),
        .fwdBD (forwardBD),
        .fwdAE (fwdAE),
        .fwdBE (fwdBE)
    );

    hazardArbiter hazardArbiter_inst (
        .clk        (clk),
        .rstN       (rstN),
        .iWait      (iWait),
        .dWait      (dWait),
        .eWait      (eWait),
        .redirect   (decRedirect),
        .mMultiAlu  (mStage.multiAlu),
        .loadUseReq (loadUseReq),
        .branchReq  (branchReq),
        .multiReq   (multiReq),
        .fwdAEIn    (fwdAE),
        .fwdBEIn    (fwdBE),
        .stallF     (stallF),
        .stallD     (stallD),
        .stallE     (stallE),
        .stallM     (stallM),
        .flushD     (flushD),
        .flushE     (flushE),
        .flushM     (flushM),
        .forwardAE  (forwardAE),
        .forwardBE  (forwardBE)
    );

endmodule

// File: verilog/hazardPkg.sv
package hazardPkg;

    localparam int regAddrW = 5;

    typedef logic [regAddrW-1:0] regAddrT;

    localparam regAddrT regZero = '0;    // Reads as zero and never creates a hazard.

    // Operand source for the forwarding muxes in decode and execute.
    typedef enum logic [1:0] {
        fwdNone  = 2'b00,    // Value comes from the register file.
        fwdFromW = 2'b01,
        fwdFromM = 2'b10
    } fwdSelT;

    // Instruction held in execute.
    typedef struct packed {
        regAddrT ra1;
        regAddrT ra2;
        regAddrT dst;
        logic    wr;
        logic    memRead;
        logic    multiAlu;
    } eStageT;

    // Instruction held in memory.
    typedef struct packed {
        regAddrT dst;
        logic    wr;
        logic    memRead;
        logic    multiAlu;    // Result came from the multi-cycle unit.
    } mStageT;

    // Instruction held in writeback.
    typedef struct packed {
        regAddrT dst;
        logic    wr;
    } wStageT;

endpackage

// File: verilog/pipeReg.sv
`timescale 1ns/100ps

module pipeReg #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    hold,
    input  logic    bubble,
    input  payloadT d,
    output payloadT q
);

    // An all-zero record carries no write and no memory read, so it acts as a bubble.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

    // A stage is either frozen or emptied in one cycle, never both.
    holdBubbleExcl: assert property (
        @(posedge clk) disable iff (!rstN)
        !(hold && bubble)
    ) else $error("pipeReg: hold and bubble asserted together");

endmodule

// File: verilog/stallDetect.sv
`timescale 1ns/100ps

module stallDetect
    import hazardPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT ra1,
    input  regAddrT ra2,
    input  logic    branchUse,
    input  logic    multiAlu,
    input  regAddrT eDst,
    input  logic    eWr,
    input  logic    eMemRead,
    input  regAddrT mDst,
    input  logic    mWr,
    input  logic    mMemRead,
    output logic    loadUseReq,
    output logic    branchReq,
    output logic    multiReq
);

    logic eMatch1;
    logic eMatch2;
    logic mMatch1;
    logic mMatch2;
    logic earlyDep;
    logic mWrDep;

    assign eMatch1 = (ra1 == eDst);
    assign eMatch2 = (ra2 == eDst);
    assign mMatch1 = (ra1 == mDst);
    assign mMatch2 = (ra2 == mDst);

    // Operands needed in decode that are still being produced in execute,
    // or still being loaded in memory.
    assign earlyDep = (eWr && (eMatch1 || eMatch2))
                    || (mMemRead && (mMatch1 || mMatch2));

    // The multi-cycle unit also waits for any memory-stage result.
    assign mWrDep = mWr && (((ra1 != regZero) && mMatch1)
                         || ((ra2 != regZero) && mMatch2));

    assign loadUseReq = eMemRead && (eDst != regZero) && (eMatch1 || eMatch2);
    assign branchReq  = branchUse && earlyDep;    // Branch compares in decode.
    assign multiReq   = multiAlu && (earlyDep || mWrDep);

    // A load into register zero has no consumer to hold back.
    loadUseNoZero: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(loadUseReq) |-> (eDst != regZero)
    ) else $error("stallDetect: load-use stall raised on register zero");

endmodule
